// ==== flist.f ====
+incdir+verification
design/mipsPkg.sv
design/fetchStage.sv
design/decodeStage.sv
design/regFile.sv
design/executeStage.sv
design/memStage.sv
design/mipsCore.sv
verification/tbTop.sv

// ==== verification/tbModel.svh ====
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

localparam int ProgWords = 256;             // Instruction memory depth
localparam int DataWords = 1024;            // Covers byte addresses up to 0xFFC

logic [15:0]    lfsrState;
mipsPkg::word_t prog [0:ProgWords-1];       // Program image, also the imem model
int             progLen;
int             markerIdx;                  // End marker store
mipsPkg::word_t modelRegs [0:31];
mipsPkg::word_t modelMem [0:DataWords-1];
mipsPkg::word_t expAddr [$];                // Expected stores in program order
mipsPkg::word_t expData [$];

function automatic logic [15:0] lfsrStep(input logic [15:0] s);
  return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);  // Galois, taps 16 14 13 11
endfunction

function automatic logic [31:0] randBits(input int n);
  logic [31:0] r;
  r = '0;
  for (int i = 0; i < n; i++) begin
    r = {r[30:0], lfsrState[0]};            // One step per bit
    lfsrState = lfsrStep(lfsrState);
  end
  return r;
endfunction

function automatic mipsPkg::word_t fillWord(input logic [31:0] addr);
  return (addr * 32'h9E3779B1) ^ {addr[15:0], addr[31:16]};
endfunction

function automatic mipsPkg::word_t encR(input logic [4:0] rs, input logic [4:0] rt,
                                        input logic [4:0] rd, input logic [5:0] fn);
  return {mipsPkg::OpSpecial, rs, rt, rd, 5'd0, fn};
endfunction

function automatic mipsPkg::word_t encI(input logic [5:0] op, input logic [4:0] rs,
                                        input logic [4:0] rt, input logic [15:0] imm);
  return {op, rs, rt, imm};
endfunction

function automatic logic [4:0] randReg();
  return 5'(32'd1 + randBits(3) % 32'd7);   // r1 to r7
endfunction

task automatic emit(input mipsPkg::word_t w);
  prog[progLen] = w;
  progLen++;
endtask

task automatic addRandomInstr(input int lastIdx);
  logic [2:0] kind;
  logic [4:0] rs, rt, rd;
  int         maxOff;
  kind   = 3'(randBits(3));
  rs     = randReg();
  rt     = randReg();
  rd     = randReg();
  maxOff = lastIdx - progLen - 1;           // Forward only, never past lastIdx
  case (kind)
    3'd0: emit(encR(rs, rt, rd, mipsPkg::FnAdd));
    3'd1: emit(encR(rs, rt, rd, mipsPkg::FnSllv));
    3'd2: emit(encR(rs, rt, rd, mipsPkg::FnSrlv));
    3'd3: emit(encI(mipsPkg::OpAddi, rs, rt, 16'(randBits(16))));
    3'd4: emit(encI(mipsPkg::OpLw, 5'd0, rt, 16'(randBits(8) << 2)));
    3'd5: emit(encI(mipsPkg::OpSw, 5'd0, rt, 16'(randBits(8) << 2)));
    3'd6: emit(encI(mipsPkg::OpBeq, rs, rt, 16'(randBits(4) % (maxOff + 1))));
    default: emit(encI(mipsPkg::OpBne, rs, rt, 16'(randBits(4) % (maxOff + 1))));
  endcase
endtask

task automatic buildProgram();
  int dumpIdx;
  lfsrState = 16'd58416;
  progLen   = 0;
  for (int i = 0; i < ProgWords; i++) begin
    prog[i] = '0;                           // Nop
  end
  for (int n = 1; n < 32; n++) begin
    emit(encI(mipsPkg::OpAddi, 5'd0, 5'(n), 16'(randBits(16))));  // Known start values
  end
  emit(encI(mipsPkg::OpLw, 5'd0, 5'd10, 16'h0104));
  emit(encR(5'd10, 5'd12, 5'd11, mipsPkg::FnAdd));   // Uses load result at once
  emit(encI(mipsPkg::OpBeq, 5'd16, 5'd16, 16'd2));   // Taken
  emit(encI(mipsPkg::OpSw, 5'd0, 5'd17, 16'h0200));  // Squashed
  emit(encI(mipsPkg::OpSw, 5'd0, 5'd17, 16'h0204));  // Squashed
  emit(encI(mipsPkg::OpBne, 5'd18, 5'd18, 16'd1));   // Not taken
  emit(encI(mipsPkg::OpSw, 5'd0, 5'd19, 16'h0208));  // Fall-through, must appear
  emit(encI(mipsPkg::OpAddi, 5'd0, 5'd22, 16'd37));  // Shift amount above 31
  emit(encI(mipsPkg::OpAddi, 5'd0, 5'd27, 16'd64));
  emit(encR(5'd22, 5'd24, 5'd25, mipsPkg::FnSllv));
  emit(encR(5'd22, 5'd25, 5'd26, mipsPkg::FnSrlv));  // Forwarded from mem stage
  emit(encR(5'd27, 5'd24, 5'd28, mipsPkg::FnSrlv));  // Acts as shift by 0
  emit(encR(5'd25, 5'd26, 5'd29, mipsPkg::FnAdd));
  emit(encR(5'd29, 5'd29, 5'd29, mipsPkg::FnAdd));   // Back-to-back chain
  emit(encR(5'd29, 5'd25, 5'd30, mipsPkg::FnAdd));
  dumpIdx = progLen + 40;
  for (int k = 0; k < 40; k++) begin
    addRandomInstr(dumpIdx);
  end
  for (int n = 1; n < 32; n++) begin
    emit(encI(mipsPkg::OpSw, 5'd0, 5'(n), 16'(32'h800 + 4 * n)));  // Register dump
  end
  markerIdx = progLen;
  emit(encI(mipsPkg::OpSw, 5'd0, 5'd0, 16'h0FFC));
  emit(encI(mipsPkg::OpBeq, 5'd0, 5'd0, 16'hFFFF));  // Self-loop
endtask

task automatic writeReg(input logic [4:0] r, input mipsPkg::word_t v);
  if (r != 5'd0) begin
    modelRegs[r] = v;
  end
endtask

// Sequential reference, no delay slot
task automatic runModel();
  mipsPkg::word_t w, a, b, imm, ea;
  logic [4:0]     rs, rt, rd;
  int             pcIdx, nextIdx, steps;
  for (int i = 0; i < 32; i++) begin
    modelRegs[i] = '0;
  end
  for (int i = 0; i < DataWords; i++) begin
    modelMem[i] = fillWord(32'(i) * 32'd4);
  end
  pcIdx = 0;
  steps = 0;
  while (pcIdx != markerIdx && steps < 2000) begin
    w       = prog[pcIdx];
    rs      = w[25:21];
    rt      = w[20:16];
    rd      = w[15:11];
    imm     = {{16{w[15]}}, w[15:0]};
    a       = modelRegs[rs];
    b       = modelRegs[rt];
    ea      = a + imm;
    nextIdx = pcIdx + 1;
    case (w[31:26])
      mipsPkg::OpSpecial: begin
        case (w[5:0])
          mipsPkg::FnAdd:  writeReg(rd, a + b);
          mipsPkg::FnSllv: writeReg(rd, b << a[4:0]);
          mipsPkg::FnSrlv: writeReg(rd, b >> a[4:0]);
          default: ;
        endcase
      end
      mipsPkg::OpAddi: writeReg(rt, ea);
      mipsPkg::OpLw:   writeReg(rt, modelMem[ea[11:2]]);
      mipsPkg::OpSw: begin
        modelMem[ea[11:2]] = b;
        expAddr.push_back(ea);
        expData.push_back(b);
      end
      mipsPkg::OpBeq: if (a == b) nextIdx = pcIdx + 1 + int'($signed(imm));
      mipsPkg::OpBne: if (a != b) nextIdx = pcIdx + 1 + int'($signed(imm));
      default: ;
    endcase
    pcIdx = nextIdx;
    steps++;
  end
endtask

`endif

// ==== verification/tbTop.sv ====
module tbTop;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int AddrWidth     = 16;
  localparam int MaxWaitCycles = 2000;       // Limit for the end marker

  logic                 CLK;
  logic                 RST_X;
  logic [AddrWidth-1:0] iAddr;
  mipsPkg::word_t       iData = '0;
  mipsPkg::word_t       dAddr;
  mipsPkg::word_t       dWrData;
  mipsPkg::word_t       dRdData = '0;
  logic [3:0]           dWe;
  logic                 dOe;

  `include "tbModel.svh"

  mipsPkg::word_t dmem [0:DataWords-1];      // Data memory model
  logic [7:0]     fetchIdx = '0;             // Address seen mid-cycle
  logic [9:0]     loadIdx  = '0;
  logic           loadReq  = 1'b0;
  int             obsCount = 0;              // Stores checked so far
  logic           endSeen  = 1'b0;

  mipsCore #(.AddrWidth(AddrWidth)) u_dut (
    .CLK, .RST_X, .iAddr, .iData, .dAddr, .dWrData, .dRdData, .dWe, .dOe
  );

  task automatic failRun(input string why);
    $display("%s", why);
    $display("Regression failed");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic checkValue(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    if (actual !== expected) begin
      failRun($sformatf("ERR %s expected %h actual %h", name, expected, actual));
    end
  endtask

  task automatic checkStore(input mipsPkg::word_t addr, input mipsPkg::word_t data);
    if (addr == 32'h0000_0FFC) begin
      endSeen = 1'b1;                        // End marker
    end else if (obsCount >= expAddr.size()) begin
      failRun($sformatf("Store to %h seen after all %0d expected stores",
                        addr, expAddr.size()));
    end else begin
      checkValue($sformatf("store %0d address", obsCount), expAddr[obsCount], addr);
      checkValue($sformatf("store %0d data", obsCount), expData[obsCount], data);
      obsCount++;
    end
  endtask

  initial begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;
  end

  // Ports sampled mid-cycle where DUT outputs are settled
  always @(negedge CLK) begin
    fetchIdx = iAddr[9:2];
    loadIdx  = dAddr[11:2];
    loadReq  = RST_X && dOe;
    if (RST_X && dWe != 4'b0000) begin
      checkValue("store byte enables", 32'hF, 32'(dWe));
      dmem[dAddr[11:2]] = dWrData;
      checkStore(dAddr, dWrData);
    end
  end

  // Read data one edge after the address
  always @(posedge CLK) begin
    #1;
    iData = prog[fetchIdx];
    if (loadReq) begin
      dRdData = dmem[loadIdx];
    end
  end

  initial begin : testSequence
    int cycles;
    RST_X = 1'b0;
    buildProgram();
    runModel();
    for (int i = 0; i < DataWords; i++) begin
      dmem[i] = fillWord(32'(i) * 32'd4);    // Same image the model starts from
    end
    repeat (4) @(posedge CLK);
    #1 RST_X = 1'b1;
    @(negedge CLK);
    checkValue("reset iAddr", 32'h0, 32'(iAddr));
    checkValue("reset dWe", 32'h0, 32'(dWe));
    checkValue("reset dOe", 32'h0, 32'(dOe));
    cycles = 0;
    while (!endSeen && cycles < MaxWaitCycles) begin
      @(posedge CLK);
      cycles++;
    end
    if (!endSeen) begin
      failRun("Timeout: the end marker store did not appear within 2000 cycles");
    end else begin
      checkValue("store count", 32'(expAddr.size()), 32'(obsCount));
      $display("Regression passed");
      $finish;
    end
  end

endmodule

// ==== design/mipsCore.sv ====
module mipsCore #(
  parameter int AddrWidth = 16
) (
  input  logic                 CLK,
  input  logic                 RST_X,
  output logic [AddrWidth-1:0] iAddr,
  input  mipsPkg::word_t       iData,
  output mipsPkg::word_t       dAddr,
  output mipsPkg::word_t       dWrData,
  input  mipsPkg::word_t       dRdData,
  output logic [3:0]           dWe,
  output logic                 dOe
);

  mipsPkg::word_t       instr;           // Fetch to decode
  logic [AddrWidth-1:0] pc4;
  logic                 stall;
  logic                 redirect;        // Taken branch strobe
  logic [AddrWidth-1:0] redirectPc;
  mipsPkg::regIdx_t     rsIdx, rtIdx;    // Register file reads
  mipsPkg::word_t       rsData, rtData;
  mipsPkg::aluOp_t      aluOp;           // Decode to execute
  logic                 useImm, isLoad, isStore, isBeq, isBne;
  mipsPkg::regIdx_t     rsNum, rtNum, dest;
  mipsPkg::word_t       opA, opB, storeData;
  logic [AddrWidth-1:0] branchTarget;
  logic                 exIsLoad;        // Interlock feedback
  mipsPkg::regIdx_t     exDest;
  mipsPkg::word_t       memAddr, memStoreData;  // Execute to memory
  logic                 memIsLoad, memIsStore;
  mipsPkg::regIdx_t     memDest;
  mipsPkg::regIdx_t     wbDest;          // Writeback to regs and forwarding
  mipsPkg::word_t       wbData;

  fetchStage #(.AddrWidth(AddrWidth)) fetch (
    .CLK, .RST_X, .stall, .redirect, .redirectPc,
    .iAddr, .iData, .instr, .pc4
  );

  decodeStage #(.AddrWidth(AddrWidth)) decode (
    .CLK, .RST_X, .instr, .pc4, .redirect, .exIsLoad, .exDest,
    .rsIdx, .rtIdx, .rsData, .rtData, .stall,
    .aluOp, .useImm, .isLoad, .isStore, .isBeq, .isBne,
    .rsNum, .rtNum, .dest, .opA, .opB, .storeData, .branchTarget
  );

  regFile regs (
    .CLK, .rsIdx, .rtIdx, .rsData, .rtData, .wbDest, .wbData
  );

  executeStage #(.AddrWidth(AddrWidth)) execute (
    .CLK, .RST_X,
    .aluOp, .useImm, .isLoad, .isStore, .isBeq, .isBne,
    .rsNum, .rtNum, .dest, .opA, .opB, .storeData, .branchTarget,
    .wbDest, .wbData, .redirect, .redirectPc, .exIsLoad, .exDest,
    .memAddr, .memStoreData, .memIsLoad, .memIsStore, .memDest
  );

  memStage mem (
    .CLK, .RST_X, .memAddr, .memStoreData, .memIsLoad, .memIsStore, .memDest,
    .dAddr, .dWrData, .dWe, .dOe, .dRdData, .wbDest, .wbData
  );

endmodule

// ==== design/memStage.sv ====
module memStage (
  input  logic             CLK,
  input  logic             RST_X,
  input  mipsPkg::word_t   memAddr,
  input  mipsPkg::word_t   memStoreData,
  input  logic             memIsLoad,
  input  logic             memIsStore,
  input  mipsPkg::regIdx_t memDest,
  output mipsPkg::word_t   dAddr,
  output mipsPkg::word_t   dWrData,
  output logic [3:0]       dWe,          // Byte enables, full word only
  output logic             dOe,
  input  mipsPkg::word_t   dRdData,      // Arrives in writeback
  output mipsPkg::regIdx_t wbDest,
  output mipsPkg::word_t   wbData
);

  logic           wbIsLoad;
  mipsPkg::word_t wbResult;              // ALU result carried to writeback

  assign dAddr   = memAddr;
  assign dWrData = memStoreData;
  assign dWe     = memIsStore ? 4'b1111 : 4'b0000;
  assign dOe     = memIsLoad;

  always_ff @(posedge CLK) begin
    if (!RST_X) begin
      wbIsLoad <= 1'b0;
      wbDest   <= '0;
    end else begin
      wbIsLoad <= memIsLoad;
      wbDest   <= memDest;
    end
  end

  always_ff @(posedge CLK) begin
    wbResult <= memAddr;
  end

  assign wbData = wbIsLoad ? dRdData : wbResult;  // Memory data for lw

  // Execute never flags a slot as both load and store
  loadStoreExclusive : assert property (@(posedge CLK) disable iff (!RST_X)
    !(dOe && dWe != 4'b0000))
    else $error("Data read and write in the same cycle");

endmodule

// ==== design/executeStage.sv ====
module executeStage #(
  parameter int AddrWidth = 16
) (
  input  logic                 CLK,
  input  logic                 RST_X,
  input  mipsPkg::aluOp_t      aluOp,
  input  logic                 useImm,
  input  logic                 isLoad,
  input  logic                 isStore,
  input  logic                 isBeq,
  input  logic                 isBne,
  input  mipsPkg::regIdx_t     rsNum,
  input  mipsPkg::regIdx_t     rtNum,
  input  mipsPkg::regIdx_t     dest,
  input  mipsPkg::word_t       opA,
  input  mipsPkg::word_t       opB,
  input  mipsPkg::word_t       storeData,
  input  logic [AddrWidth-1:0] branchTarget,
  input  mipsPkg::regIdx_t     wbDest,
  input  mipsPkg::word_t       wbData,
  output logic                 redirect,
  output logic [AddrWidth-1:0] redirectPc,
  output logic                 exIsLoad,
  output mipsPkg::regIdx_t     exDest,
  output mipsPkg::word_t       memAddr,       // ALU result or data address
  output mipsPkg::word_t       memStoreData,
  output logic                 memIsLoad,
  output logic                 memIsStore,
  output mipsPkg::regIdx_t     memDest
);

  mipsPkg::regIdx_t memFwdDest;               // Mem stage result usable for forwarding
  mipsPkg::word_t   aluA;
  mipsPkg::word_t   rtVal;
  mipsPkg::word_t   aluB;
  mipsPkg::word_t   aluOut;
  logic             squashSlot;               // Cycle after a taken branch

  // Memory stage wins over writeback, it is the younger result
  function automatic mipsPkg::word_t forward(
    input mipsPkg::regIdx_t src,
    input mipsPkg::word_t   regVal,
    input mipsPkg::regIdx_t memSrc,
    input mipsPkg::word_t   memVal,
    input mipsPkg::regIdx_t wbSrc,
    input mipsPkg::word_t   wbVal
  );
    if (src != '0 && src == memSrc) begin
      return memVal;
    end
    if (src != '0 && src == wbSrc) begin
      return wbVal;
    end
    return regVal;
  endfunction

  assign memFwdDest = memIsLoad ? '0 : memDest;  // Load data only via writeback
  assign aluA  = forward(rsNum, opA, memFwdDest, memAddr, wbDest, wbData);
  assign rtVal = forward(rtNum, storeData, memFwdDest, memAddr, wbDest, wbData);
  assign aluB  = useImm ? opB : rtVal;

  always_comb begin
    case (aluOp)
      mipsPkg::AluSllv: aluOut = aluB << aluA[4:0];  // Shift amount from rs
      mipsPkg::AluSrlv: aluOut = aluB >> aluA[4:0];  // Logical
      default:          aluOut = aluA + aluB;
    endcase
  end

  // Predict not taken, so only a taken branch redirects
  assign redirect   = !squashSlot && ((isBeq && aluA == rtVal) ||
                                      (isBne && aluA != rtVal));
  assign redirectPc = branchTarget;
  assign exIsLoad   = isLoad && !squashSlot;     // For the decode interlock
  assign exDest     = squashSlot ? '0 : dest;

  always_ff @(posedge CLK) begin
    if (!RST_X) begin
      squashSlot <= 1'b0;
      memIsLoad  <= 1'b0;
      memIsStore <= 1'b0;
      memDest    <= '0;
    end else begin
      squashSlot <= redirect;
      memIsLoad  <= isLoad && !squashSlot;
      memIsStore <= isStore && !squashSlot;
      memDest    <= squashSlot ? '0 : dest;
    end
  end

  always_ff @(posedge CLK) begin
    memAddr      <= aluOut;
    memStoreData <= rtVal;                       // Forwarded store value
  end

  // Both slots behind a taken branch arrive from decode as bubbles
  squashedNoStore : assert property (@(posedge CLK) disable iff (!RST_X)
    redirect |=> (!isStore && !isLoad) [*2])
    else $error("Memory access in a slot squashed by a taken branch");

endmodule

// ==== design/regFile.sv ====
module regFile (
  input  logic             CLK,
  input  mipsPkg::regIdx_t rsIdx,
  input  mipsPkg::regIdx_t rtIdx,
  output mipsPkg::word_t   rsData,
  output mipsPkg::word_t   rtData,
  input  mipsPkg::regIdx_t wbDest,   // Zero when nothing to write
  input  mipsPkg::word_t   wbData
);

  mipsPkg::word_t regs [0:31];

  // Same-cycle write shows up on the read port
  assign rsData = (rsIdx == '0)     ? '0     :
                  (rsIdx == wbDest) ? wbData : regs[rsIdx];
  assign rtData = (rtIdx == '0)     ? '0     :
                  (rtIdx == wbDest) ? wbData : regs[rtIdx];

  always_ff @(posedge CLK) begin
    if (wbDest != '0) begin          // r0 stays zero
      regs[wbDest] <= wbData;
    end
  end

endmodule

// ==== design/decodeStage.sv ====
module decodeStage #(
  parameter int AddrWidth = 16
) (
  input  logic                    CLK,
  input  logic                    RST_X,
  input  mipsPkg::word_t          instr,
  input  logic [AddrWidth-1:0]    pc4,
  input  logic                    redirect,
  input  logic                    exIsLoad,      // Load now in execute
  input  mipsPkg::regIdx_t        exDest,
  output mipsPkg::regIdx_t        rsIdx,         // Register file read ports
  output mipsPkg::regIdx_t        rtIdx,
  input  mipsPkg::word_t          rsData,
  input  mipsPkg::word_t          rtData,
  output logic                    stall,
  output mipsPkg::aluOp_t         aluOp,
  output logic                    useImm,
  output logic                    isLoad,
  output logic                    isStore,
  output logic                    isBeq,
  output logic                    isBne,
  output mipsPkg::regIdx_t        rsNum,
  output mipsPkg::regIdx_t        rtNum,
  output mipsPkg::regIdx_t        dest,
  output mipsPkg::word_t          opA,
  output mipsPkg::word_t          opB,           // Immediate or rt value
  output mipsPkg::word_t          storeData,
  output logic [AddrWidth-1:0]    branchTarget
);

  mipsPkg::opcode_t     opcode;
  mipsPkg::funct_t      funct;
  mipsPkg::regIdx_t     rs;
  mipsPkg::regIdx_t     rt;
  mipsPkg::regIdx_t     rd;
  mipsPkg::word_t       imm32;
  mipsPkg::aluOp_t      aluOpD;
  mipsPkg::regIdx_t     destD;
  logic [AddrWidth-1:0] targetD;
  logic                 isR, isAddi, isLw, isSw, isBeqD, isBneD;
  logic                 useImmD;
  logic                 rtIsSrc;                 // rt read as an operand
  logic                 squashNext;              // Second younger slot of a branch
  logic                 bubble;

  assign opcode = mipsPkg::opcode_t'(instr[31:26]);
  assign funct  = mipsPkg::funct_t'(instr[5:0]);
  assign rs     = instr[25:21];
  assign rt     = instr[20:16];
  assign rd     = instr[15:11];
  assign imm32  = {{16{instr[15]}}, instr[15:0]};  // Sign extend
  assign rsIdx  = rs;
  assign rtIdx  = rt;

  assign isR    = opcode == mipsPkg::OpSpecial;
  assign isAddi = opcode == mipsPkg::OpAddi;
  assign isLw   = opcode == mipsPkg::OpLw;
  assign isSw   = opcode == mipsPkg::OpSw;
  assign isBeqD = opcode == mipsPkg::OpBeq;
  assign isBneD = opcode == mipsPkg::OpBne;

  always_comb begin
    aluOpD = mipsPkg::AluAdd;                    // add, addi, lw, sw
    if (isR && funct == mipsPkg::FnSllv) begin
      aluOpD = mipsPkg::AluSllv;
    end else if (isR && funct == mipsPkg::FnSrlv) begin
      aluOpD = mipsPkg::AluSrlv;
    end
  end

  assign useImmD = isAddi || isLw || isSw;
  assign rtIsSrc = isR || isSw || isBeqD || isBneD;
  assign destD   = isR ? rd : (isAddi || isLw) ? rt : '0;  // Branch/store write nothing
  assign targetD = pc4 + AddrWidth'({imm32[29:0], 2'b00});

  // Loaded value not ready until writeback
  assign stall  = exIsLoad && exDest != '0 &&
                  (exDest == rs || (rtIsSrc && exDest == rt));
  assign bubble = stall || redirect || squashNext;

  always_ff @(posedge CLK) begin
    if (!RST_X) begin
      squashNext <= 1'b0;
      aluOp      <= mipsPkg::AluAdd;
      useImm     <= 1'b0;
      isLoad     <= 1'b0;
      isStore    <= 1'b0;
      isBeq      <= 1'b0;
      isBne      <= 1'b0;
      rsNum      <= '0;
      rtNum      <= '0;
      dest       <= '0;
    end else begin
      squashNext <= redirect;
      aluOp      <= aluOpD;
      useImm     <= useImmD;
      rsNum      <= rs;
      rtNum      <= rt;
      isLoad     <= !bubble && isLw;             // Bubble: no access, branch or write
      isStore    <= !bubble && isSw;
      isBeq      <= !bubble && isBeqD;
      isBne      <= !bubble && isBneD;
      dest       <= bubble ? '0 : destD;
    end
  end

  always_ff @(posedge CLK) begin
    opA          <= rsData;
    opB          <= useImmD ? imm32 : rtData;
    storeData    <= rtData;
    branchTarget <= targetD;
  end

  // Bubble in execute after an interlock cannot be a load
  singleCycleStall : assert property (@(posedge CLK) disable iff (!RST_X)
    stall |=> !stall)
    else $error("Load-use interlock lasted more than one cycle");

endmodule

// ==== design/fetchStage.sv ====
module fetchStage #(
  parameter int AddrWidth = 16
) (
  input  logic                 CLK,
  input  logic                 RST_X,
  input  logic                 stall,       // Load-use interlock from decode
  input  logic                 redirect,    // Taken branch from execute
  input  logic [AddrWidth-1:0] redirectPc,
  output logic [AddrWidth-1:0] iAddr,
  input  mipsPkg::word_t       iData,       // Returned one edge after iAddr
  output mipsPkg::word_t       instr,
  output logic [AddrWidth-1:0] pc4
);

  logic [AddrWidth-1:0] pc;                 // Address being fetched now
  logic [AddrWidth-1:0] pcNext;             // Sequential successor
  logic                 fetched;            // iData carries a real fetch
  logic                 replay;             // Serve the held word this cycle
  mipsPkg::word_t       heldInstr;          // Word captured during interlock

  assign iAddr  = pc;
  assign pcNext = pc + AddrWidth'(mipsPkg::PcStride);

  // First cycle out of reset has no fetched word yet, so decode sees a nop
  assign instr = !fetched ? '0 :
                 replay   ? heldInstr : iData;

  always_ff @(posedge CLK) begin
    if (!RST_X) begin
      pc      <= '0;
      fetched <= 1'b0;
      replay  <= 1'b0;
    end else begin
      fetched <= 1'b1;
      replay  <= stall;                     // Memory moves on, decode holds
      if (redirect) begin
        pc <= redirectPc;                   // Target fetched next cycle
      end else if (!stall) begin
        pc <= pcNext;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (!stall) begin
      pc4 <= pcNext;                        // Tracks the word on iData
    end
    if (stall) begin
      heldInstr <= instr;                   // Would be lost otherwise
    end
  end

  // Execute holds either a load or a branch, never both
  stallRedirectExclusive : assert property (@(posedge CLK) disable iff (!RST_X)
    !(stall && redirect))
    else $error("Interlock and branch redirect in the same cycle");

endmodule

// ==== design/mipsPkg.sv ====
package mipsPkg;

  typedef logic [31:0] word_t;    // Data word
  typedef logic [4:0]  regIdx_t;  // Register number, zero means no destination

  // Primary opcodes of the supported subset
  typedef enum logic [5:0] {
    OpSpecial = 6'h00,            // R format, operation in funct
    OpBeq     = 6'h04,
    OpBne     = 6'h05,
    OpAddi    = 6'h08,
    OpLw      = 6'h23,
    OpSw      = 6'h2b
  } opcode_t;

  // R format function codes
  typedef enum logic [5:0] {
    FnSllv = 6'h04,
    FnSrlv = 6'h06,
    FnAdd  = 6'h20
  } funct_t;

  // Operation selected in execute
  typedef enum logic [1:0] {
    AluAdd,                       // Also address calc for lw/sw
    AluSllv,
    AluSrlv
  } aluOp_t;

  localparam int unsigned PcStride = 4;  // Bytes per instruction

endpackage
